// File: logic/axis_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Client stream definitions for the 10G transmit path.
// Every client packet starts with PAD_BYTES of internal padding, which the
// transmit path strips. tuser[2:0] is the byte count of the last beat,
// where 0 means a full beat. tuser[3] is the error bit and is ignored.
////////////////////////////////////////////////////////////////////////////

package axis_pkg;

  // Stream beat
  localparam int DATA_W     = 64;
  localparam int BEAT_BYTES = DATA_W / 8;

  // tuser layout
  localparam int TUSER_W = 4;
  localparam int OCC_W   = 3;

  // Internal padding in front of the Ethernet header
  localparam int PAD_BYTES = 6;
  localparam int PAD_W     = PAD_BYTES * 8;
  localparam int HEAD_W    = DATA_W - PAD_W;

  // First beat of a packet, seen either as a plain word or split into
  // the pad bytes (low end) and the first payload bytes (bytes 6 and 7)
  typedef union packed {
    logic [DATA_W-1:0] raw;
    struct packed {
      logic [HEAD_W-1:0] payload;
      logic [PAD_W-1:0]  pad;
    } head;
  } first_beat_u;

endpackage

// File: logic/xge_pkg.sv
////////////////////////////////////////////////////////////////////////////
// MAC-side definitions of the packet transmit interface.
// mod carries the byte count of the eop beat, 0 meaning all 8 bytes.
// It is only meaningful together with eop.
////////////////////////////////////////////////////////////////////////////

package xge_pkg;

  // Byte occupancy of the eop beat
  localparam int MOD_W = 3;

  // Every beat that is not an eop beat is full
  localparam logic [MOD_W-1:0] MOD_FULL = '0;

  // Start FSM
  //   IDLE  waiting for a complete packet and enable
  //   SEND  one beat per cycle toward the MAC
  //   HOLD  MAC full, packet paused
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    SEND = 2'd1,
    HOLD = 2'd2
  } start_state_e;

endpackage

// File: logic/axi64_to_xge64.sv
////////////////////////////////////////////////////////////////////////////
// Strips the leading pad bytes from each client packet and realigns the
// payload onto 64-bit MAC beats. Packets must be at least 7 bytes long.
// Output is registered; input ready follows output ready combinationally.
// A packet whose last beat holds more than 6 bytes costs one extra cycle.
////////////////////////////////////////////////////////////////////////////

module axi64_to_xge64 (
  input  logic                         xgmii_clk,
  input  logic                         rst_i,
  // Client stream
  input  logic [axis_pkg::DATA_W-1:0]  s_tdata_i,
  input  logic [axis_pkg::TUSER_W-1:0] s_tuser_i,
  input  logic                         s_tlast_i,
  input  logic                         s_tvalid_i,
  output logic                         s_tready_o,
  // Realigned beats toward the packet FIFO
  output logic [axis_pkg::DATA_W-1:0]  m_data_o,
  output logic [xge_pkg::MOD_W-1:0]    m_mod_o,
  output logic                         m_sop_o,
  output logic                         m_eop_o,
  output logic                         m_valid_o,
  input  logic                         m_ready_i
);

  localparam int CNT_BITS = axis_pkg::OCC_W + 1;

  axis_pkg::first_beat_u beat;

  logic [axis_pkg::HEAD_W-1:0] hold_q;
  logic [xge_pkg::MOD_W-1:0]   tail_mod_q;
  logic                        first_q;
  logic                        sop_pend_q;
  logic                        tail_q;

  logic                out_adv;
  logic                in_fire;
  logic [CNT_BITS-1:0] last_cnt;
  logic [CNT_BITS-1:0] tail_cnt;
  logic [CNT_BITS-1:0] short_cnt;
  logic                long_last;

  assign beat = axis_pkg::first_beat_u'(s_tdata_i);

  // Output register free or being drained this cycle
  assign out_adv    = !m_valid_o || m_ready_i;
  assign s_tready_o = out_adv && !tail_q;
  assign in_fire    = s_tvalid_i && s_tready_o;

  ////////////////////////////////////////////////////////////////////////////
  // Last beat byte accounting
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    if (s_tuser_i[axis_pkg::OCC_W-1:0] == '0) begin
      last_cnt = CNT_BITS'(axis_pkg::BEAT_BYTES);
    end else begin
      last_cnt = {1'b0, s_tuser_i[axis_pkg::OCC_W-1:0]};
    end
  end

  // More than the pad width left over means a tail beat is needed
  assign long_last = last_cnt > CNT_BITS'(axis_pkg::PAD_BYTES);
  assign tail_cnt  = last_cnt - CNT_BITS'(axis_pkg::PAD_BYTES);
  // 8 wraps to 0, which is the full-beat code
  assign short_cnt = last_cnt + CNT_BITS'(axis_pkg::BEAT_BYTES - axis_pkg::PAD_BYTES);

  ////////////////////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge xgmii_clk) begin
    if (rst_i) begin
      first_q    <= 1'b1;
      sop_pend_q <= 1'b0;
      tail_q     <= 1'b0;
      m_valid_o  <= 1'b0;
    end else if (out_adv) begin
      if (tail_q) begin
        m_valid_o  <= 1'b1;
        sop_pend_q <= 1'b0;
        tail_q     <= 1'b0;
      end else if (in_fire) begin
        first_q <= s_tlast_i;
        if (first_q) begin
          // Only pad and two payload bytes so far, nothing to emit
          m_valid_o  <= 1'b0;
          sop_pend_q <= 1'b1;
          tail_q     <= s_tlast_i;
        end else begin
          m_valid_o  <= 1'b1;
          sop_pend_q <= 1'b0;
          tail_q     <= s_tlast_i && long_last;
        end
      end else begin
        m_valid_o <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Payload
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge xgmii_clk) begin
    if (out_adv) begin
      if (tail_q) begin
        // Leftover bytes 6 and 7 of the last input beat
        m_data_o <= {{axis_pkg::PAD_W{1'b0}}, hold_q};
        m_mod_o  <= tail_mod_q;
        m_sop_o  <= sop_pend_q;
        m_eop_o  <= 1'b1;
      end else if (in_fire) begin
        // Bytes 6 and 7 wait for the next beat
        hold_q     <= beat.head.payload;
        m_data_o   <= {beat.raw[axis_pkg::PAD_W-1:0], hold_q};
        m_sop_o    <= sop_pend_q;
        m_eop_o    <= s_tlast_i && !long_last;
        tail_mod_q <= tail_cnt[xge_pkg::MOD_W-1:0];
        if (s_tlast_i && !long_last) begin
          m_mod_o <= short_cnt[xge_pkg::MOD_W-1:0];
        end else begin
          m_mod_o <= xge_pkg::MOD_FULL;
        end
      end
    end
  end

  // Client must keep a beat offered until it is taken
  a_valid_held : assert property (@(posedge xgmii_clk) disable iff (rst_i)
    s_tvalid_i && !s_tready_o |=> s_tvalid_i);

endmodule

// File: logic/tx_pkt_fifo.sv
////////////////////////////////////////////////////////////////////////////
// Packet FIFO between the stripper and the MAC, 2**FIFO_AW beats deep.
// First-word-fall-through: the head is visible one cycle after the write.
// sop and eop at the head read low while the FIFO is empty.
// Writer and reader must respect not_full_o and empty_o.
////////////////////////////////////////////////////////////////////////////

module tx_pkt_fifo #(
  parameter int FIFO_AW = 6
) (
  input  logic                        xgmii_clk,
  input  logic                        rst_i,
  // Write side
  input  logic                        wr_i,
  input  logic [axis_pkg::DATA_W-1:0] wr_data_i,
  input  logic [xge_pkg::MOD_W-1:0]   wr_mod_i,
  input  logic                        wr_sop_i,
  input  logic                        wr_eop_i,
  output logic                        not_full_o,
  // Read side
  input  logic                        rd_i,
  output logic                        empty_o,
  output logic [axis_pkg::DATA_W-1:0] rd_data_o,
  output logic [xge_pkg::MOD_W-1:0]   rd_mod_o,
  output logic                        rd_sop_o,
  output logic                        rd_eop_o
);

  localparam int DEPTH  = 1 << FIFO_AW;
  localparam int WORD_W = axis_pkg::DATA_W + xge_pkg::MOD_W + 2;

  logic [WORD_W-1:0] mem [DEPTH];

  // One extra pointer bit tells full from empty
  logic [FIFO_AW:0]  wr_ptr_q;
  logic [FIFO_AW:0]  rd_ptr_q;
  logic [WORD_W-1:0] head;
  logic              head_sop;
  logic              head_eop;
  logic              full;

  assign empty_o    = wr_ptr_q == rd_ptr_q;
  assign full       = (wr_ptr_q[FIFO_AW] != rd_ptr_q[FIFO_AW]) &&
                      (wr_ptr_q[FIFO_AW-1:0] == rd_ptr_q[FIFO_AW-1:0]);
  assign not_full_o = !full;

  always_ff @(posedge xgmii_clk) begin
    if (wr_i) begin
      mem[wr_ptr_q[FIFO_AW-1:0]] <= {wr_eop_i, wr_sop_i, wr_mod_i, wr_data_i};
    end
  end

  always_ff @(posedge xgmii_clk) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (wr_i) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (rd_i) rd_ptr_q <= rd_ptr_q + 1'b1;
    end
  end

  // Head of the ring
  assign head = mem[rd_ptr_q[FIFO_AW-1:0]];
  assign {head_eop, head_sop, rd_mod_o, rd_data_o} = head;
  assign rd_sop_o = head_sop && !empty_o;
  assign rd_eop_o = head_eop && !empty_o;

  a_no_overflow : assert property (@(posedge xgmii_clk) disable iff (rst_i)
    wr_i |-> !full);

  a_no_underflow : assert property (@(posedge xgmii_clk) disable iff (rst_i)
    rd_i |-> !empty_o);

endmodule

// File: logic/tx_pkt_counter.sv
////////////////////////////////////////////////////////////////////////////
// Number of complete packets held in the packet FIFO.
// Counts eop writes up and eop reads down, one cycle after each.
// The write side must stop while the count is at its maximum.
////////////////////////////////////////////////////////////////////////////

module tx_pkt_counter #(
  parameter int CNT_W = 4
) (
  input  logic             xgmii_clk,
  input  logic             rst_i,
  // FIFO write handshake
  input  logic             in_fire_i,
  input  logic             in_eop_i,
  // FIFO read strobe
  input  logic             out_fire_i,
  input  logic             out_eop_i,
  output logic [CNT_W-1:0] pkt_count_o
);

  logic inc;
  logic dec;

  assign inc = in_fire_i && in_eop_i;
  assign dec = out_fire_i && out_eop_i;

  // Packet in and packet out in the same cycle leave the count alone
  always_ff @(posedge xgmii_clk) begin
    if (rst_i) begin
      pkt_count_o <= '0;
    end else if (inc && !dec) begin
      pkt_count_o <= pkt_count_o + 1'b1;
    end else if (dec && !inc) begin
      pkt_count_o <= pkt_count_o - 1'b1;
    end
  end

  // An eop can only leave the FIFO after it was counted in
  a_no_dec_at_zero : assert property (@(posedge xgmii_clk) disable iff (rst_i)
    dec |-> pkt_count_o != '0);

  a_no_inc_at_max : assert property (@(posedge xgmii_clk) disable iff (rst_i)
    inc && !dec |-> pkt_count_o != '1);

endmodule

// File: logic/tx_start_fsm.sv
////////////////////////////////////////////////////////////////////////////
// Read control toward the MAC. A packet is only started once it sits
// complete in the FIFO, so the MAC never runs dry mid-packet.
// ctrl_tx_enable_i gates packet starts only, never a packet in flight.
// pkt_tx_full_i stops reads in the same cycle and pauses the packet.
////////////////////////////////////////////////////////////////////////////

module tx_start_fsm #(
  parameter int CNT_W = 4
) (
  input  logic             xgmii_clk,
  input  logic             rst_i,
  // Packet FIFO status
  input  logic [CNT_W-1:0] pkt_count_i,
  input  logic             empty_i,
  input  logic             head_sop_i,
  input  logic             head_eop_i,
  // MAC side
  input  logic             ctrl_tx_enable_i,
  input  logic             pkt_tx_full_i,
  output logic             rd_o
);

  xge_pkg::start_state_e state_q;
  xge_pkg::start_state_e state_d;

  logic start_ok;

  assign start_ok = (pkt_count_i != '0) && ctrl_tx_enable_i && !pkt_tx_full_i;

  ////////////////////////////////////////////////////////////////////////////
  // Next state
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      xge_pkg::IDLE: begin
        if (start_ok) state_d = xge_pkg::SEND;
      end
      xge_pkg::SEND: begin
        // No read this cycle when full, so the eop is still at the head
        if (pkt_tx_full_i) begin
          state_d = xge_pkg::HOLD;
        end else if (head_eop_i) begin
          state_d = xge_pkg::IDLE;
        end
      end
      xge_pkg::HOLD: begin
        if (!pkt_tx_full_i) state_d = xge_pkg::SEND;
      end
      default: begin
        state_d = xge_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge xgmii_clk) begin
    if (rst_i) begin
      state_q <= xge_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // One beat per cycle while sending and the MAC has room
  assign rd_o = (state_q == xge_pkg::SEND) && !pkt_tx_full_i;

  // A counted packet must begin at the FIFO head
  a_start_on_sop : assert property (@(posedge xgmii_clk) disable iff (rst_i)
    (state_q == xge_pkg::IDLE) && (state_d != xge_pkg::IDLE) |-> head_sop_i);

  // The whole packet is present before the first read
  a_no_read_empty : assert property (@(posedge xgmii_clk) disable iff (rst_i)
    rd_o |-> !empty_i);

endmodule

// File: logic/xge_tx_path.sv
////////////////////////////////////////////////////////////////////////////
// Transmit path of the 10G MAC wrapper, single xgmii_clk domain.
// Client stream in, pad stripped, whole packets out on the MAC interface.
// A packet must fit in the FIFO, and at most 2**CNT_W-1 packets are held.
////////////////////////////////////////////////////////////////////////////

module xge_tx_path #(
  parameter int FIFO_AW = 6,
  parameter int CNT_W   = 4
) (
  input  logic                         xgmii_clk,
  input  logic                         rst_i,
  // Client stream
  input  logic [axis_pkg::DATA_W-1:0]  s_tdata_i,
  input  logic [axis_pkg::TUSER_W-1:0] s_tuser_i,
  input  logic                         s_tlast_i,
  input  logic                         s_tvalid_i,
  output logic                         s_tready_o,
  // MAC packet interface
  input  logic                         ctrl_tx_enable_i,
  input  logic                         pkt_tx_full_i,
  output logic [axis_pkg::DATA_W-1:0]  pkt_tx_data_o,
  output logic [xge_pkg::MOD_W-1:0]    pkt_tx_mod_o,
  output logic                         pkt_tx_sop_o,
  output logic                         pkt_tx_eop_o,
  output logic                         pkt_tx_val_o
);

  logic [axis_pkg::DATA_W-1:0] strip_data;
  logic [xge_pkg::MOD_W-1:0]   strip_mod;
  logic                        strip_sop;
  logic                        strip_eop;
  logic                        strip_valid;
  logic                        strip_ready;
  logic                        strip_fire;

  logic             fifo_not_full;
  logic             fifo_empty;
  logic             fifo_sop;
  logic             fifo_eop;
  logic             fifo_rd;
  logic [CNT_W-1:0] pkt_count;

  // Writes also pause while the packet counter is saturated
  assign strip_ready = fifo_not_full && !(&pkt_count);
  assign strip_fire  = strip_valid && strip_ready;

  axi64_to_xge64 u_strip (
    .xgmii_clk  (xgmii_clk),
    .rst_i      (rst_i),
    .s_tdata_i  (s_tdata_i),
    .s_tuser_i  (s_tuser_i),
    .s_tlast_i  (s_tlast_i),
    .s_tvalid_i (s_tvalid_i),
    .s_tready_o (s_tready_o),
    .m_data_o   (strip_data),
    .m_mod_o    (strip_mod),
    .m_sop_o    (strip_sop),
    .m_eop_o    (strip_eop),
    .m_valid_o  (strip_valid),
    .m_ready_i  (strip_ready)
  );

  tx_pkt_fifo #(.FIFO_AW(FIFO_AW)) u_fifo (
    .xgmii_clk  (xgmii_clk),
    .rst_i      (rst_i),
    .wr_i       (strip_fire),
    .wr_data_i  (strip_data),
    .wr_mod_i   (strip_mod),
    .wr_sop_i   (strip_sop),
    .wr_eop_i   (strip_eop),
    .not_full_o (fifo_not_full),
    .rd_i       (fifo_rd),
    .empty_o    (fifo_empty),
    .rd_data_o  (pkt_tx_data_o),
    .rd_mod_o   (pkt_tx_mod_o),
    .rd_sop_o   (fifo_sop),
    .rd_eop_o   (fifo_eop)
  );

  tx_pkt_counter #(.CNT_W(CNT_W)) u_count (
    .xgmii_clk   (xgmii_clk),
    .rst_i       (rst_i),
    .in_fire_i   (strip_fire),
    .in_eop_i    (strip_eop),
    .out_fire_i  (fifo_rd),
    .out_eop_i   (fifo_eop),
    .pkt_count_o (pkt_count)
  );

  tx_start_fsm #(.CNT_W(CNT_W)) u_start (
    .xgmii_clk        (xgmii_clk),
    .rst_i            (rst_i),
    .pkt_count_i      (pkt_count),
    .empty_i          (fifo_empty),
    .head_sop_i       (fifo_sop),
    .head_eop_i       (fifo_eop),
    .ctrl_tx_enable_i (ctrl_tx_enable_i),
    .pkt_tx_full_i    (pkt_tx_full_i),
    .rd_o             (fifo_rd)
  );

  // FIFO head goes straight to the MAC, the read strobe marks the beat
  assign pkt_tx_sop_o = fifo_sop;
  assign pkt_tx_eop_o = fifo_eop;
  assign pkt_tx_val_o = fifo_rd;

endmodule

// File: tb/tb_xge_tx_path.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the 10G transmit path. It applies a table of packet tests in
// order. Payload comes from $random with a fixed seed. A byte model gives the
// expected beats: the pad is dropped and the payload repacked eight per beat.
// Inputs change 2 units after the rising edge. Outputs are sampled at the
// falling edge.
////////////////////////////////////////////////////////////////////////////

module tb_xge_tx_path;

  localparam int FIFO_AW   = 6;
  localparam int CNT_W     = 4;
  localparam int EXP_DEPTH = 4096;
  localparam int NTEST     = 6;

  // Per test: lengths lo..hi stepped, packet count, gap mode, full pulses,
  // cycles with enable low, input stall expected
  // Gap modes: 0 none, 1 idle after each packet, 2 tlast withheld, 3 random
  localparam int T_LO     [NTEST] = '{7,  9,  7, 54,   7,  7};
  localparam int T_HI     [NTEST] = '{22, 40, 80, 54, 150, 64};
  localparam int T_STEP   [NTEST] = '{1,  5, 11,  1,  13,  9};
  localparam int T_NPKT   [NTEST] = '{16, 8, 12, 20,  16, 10};
  localparam int T_GAP    [NTEST] = '{1,  2,  3,  0,   0,  3};
  localparam int T_FULL   [NTEST] = '{0,  0,  1,  0,   0,  1};
  localparam int T_EN_LOW [NTEST] = '{0,  0,  0, 600,  0,  0};
  localparam int T_STALL  [NTEST] = '{0,  0,  0,  1,   0,  0};

  logic                         xgmii_clk;
  logic                         rst_i;
  logic [axis_pkg::DATA_W-1:0]  s_tdata_i;
  logic [axis_pkg::TUSER_W-1:0] s_tuser_i;
  logic                         s_tlast_i;
  logic                         s_tvalid_i;
  logic                         s_tready_o;
  logic                         ctrl_tx_enable_i;
  logic                         pkt_tx_full_i;
  logic [axis_pkg::DATA_W-1:0]  pkt_tx_data_o;
  logic [xge_pkg::MOD_W-1:0]    pkt_tx_mod_o;
  logic                         pkt_tx_sop_o;
  logic                         pkt_tx_eop_o;
  logic                         pkt_tx_val_o;

  integer seed;
  integer pulse_seed;
  int     cur_test;
  logic   full_on;
  int     cycle;
  int     en_until;
  int     tlast_done;
  int     out_started;
  int     stall_cycles;

  // Expected MAC beats, written by the stimulus and consumed by the monitor
  logic [63:0] exp_data [EXP_DEPTH];
  int          exp_cnt  [EXP_DEPTH];
  logic        exp_sop  [EXP_DEPTH];
  logic        exp_eop  [EXP_DEPTH];
  int          exp_wr;
  int          exp_rd;

  int err_data;
  int err_ctrl;
  int err_timing;
  int err_flow;

  xge_tx_path #(
    .FIFO_AW (FIFO_AW),
    .CNT_W   (CNT_W)
  ) DUT (
    .xgmii_clk        (xgmii_clk),
    .rst_i            (rst_i),
    .s_tdata_i        (s_tdata_i),
    .s_tuser_i        (s_tuser_i),
    .s_tlast_i        (s_tlast_i),
    .s_tvalid_i       (s_tvalid_i),
    .s_tready_o       (s_tready_o),
    .ctrl_tx_enable_i (ctrl_tx_enable_i),
    .pkt_tx_full_i    (pkt_tx_full_i),
    .pkt_tx_data_o    (pkt_tx_data_o),
    .pkt_tx_mod_o     (pkt_tx_mod_o),
    .pkt_tx_sop_o     (pkt_tx_sop_o),
    .pkt_tx_eop_o     (pkt_tx_eop_o),
    .pkt_tx_val_o     (pkt_tx_val_o)
  );

  initial begin
    xgmii_clk = 1'b0;
    forever #10 xgmii_clk = ~xgmii_clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Table helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic string test_name(input int t);
    case (t)
      0: return "single_7_22";
      1: return "tlast_withheld";
      2: return "full_pulses";
      3: return "enable_low";
      4: return "back_to_back";
      default: return "mixed_full_gaps";
    endcase
  endfunction

  function automatic int pkt_len(input int t, input int p);
    return T_LO[t] + (p * T_STEP[t]) % (T_HI[t] - T_LO[t] + 1);
  endfunction

  function automatic int table_bytes();
    int total;
    total = 0;
    for (int t = 0; t < NTEST; t++) begin
      for (int p = 0; p < T_NPKT[t]; p++) begin
        total += pkt_len(t, p);
      end
    end
    return total;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Client side driving
  ////////////////////////////////////////////////////////////////////////////

  task automatic idle_cycles(input int n);
    s_tvalid_i = 1'b0;
    s_tlast_i  = 1'b0;
    repeat (n) begin
      @(posedge xgmii_clk);
      #2;
    end
  endtask

  // Holds the beat until it is taken, returns 2 units after that edge
  task automatic drive_beat(input logic [63:0] data, input logic [3:0] user,
                            input logic last);
    s_tdata_i  = data;
    s_tuser_i  = user;
    s_tlast_i  = last;
    s_tvalid_i = 1'b1;
    @(negedge xgmii_clk);
    while (!s_tready_o) @(negedge xgmii_clk);
    @(posedge xgmii_clk);
    #2;
    if (last) tlast_done++;
  endtask

  task automatic send_packet(input int len, input int gap_mode);
    logic [7:0]  pkt [256];
    logic [63:0] word;
    logic [31:0] r;
    logic [2:0]  occ;
    logic        last;
    int          pay;
    int          nbeats;
    int          n;
    for (int i = 0; i < len; i++) begin
      r = $random(seed);
      pkt[i] = r[7:0];
    end
    // Model: pad dropped, payload packed from byte 0 of each beat
    pay = len - axis_pkg::PAD_BYTES;
    for (int b = 0; b * 8 < pay; b++) begin
      n = (pay - b * 8 > 8) ? 8 : pay - b * 8;
      word = '0;
      for (int k = 0; k < n; k++) begin
        word[8*k +: 8] = pkt[axis_pkg::PAD_BYTES + b * 8 + k];
      end
      exp_data[exp_wr] = word;
      exp_cnt[exp_wr]  = n;
      exp_sop[exp_wr]  = (b == 0);
      exp_eop[exp_wr]  = (b * 8 + n == pay);
      exp_wr++;
    end
    nbeats = (len + 7) / 8;
    occ    = 3'(len % 8);
    for (int b = 0; b < nbeats; b++) begin
      last = (b == nbeats - 1);
      if (gap_mode == 2 && last && b > 0) begin
        idle_cycles(40);
      end
      if (gap_mode == 3) begin
        r = $random(seed);
        idle_cycles(int'(r[1:0]));
      end
      // Bytes past the packet end are junk
      for (int k = 0; k < 8; k++) begin
        r = $random(seed);
        if (b * 8 + k < len) begin
          word[8*k +: 8] = pkt[b * 8 + k];
        end else begin
          word[8*k +: 8] = r[7:0];
        end
      end
      // Random error bit, which the DUT ignores
      r = $random(seed);
      drive_beat(word, {r[0], last ? occ : 3'd0}, last);
    end
    s_tvalid_i = 1'b0;
    s_tlast_i  = 1'b0;
    if (gap_mode == 1) begin
      idle_cycles(20);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // MAC side: enable and full pulses
  ////////////////////////////////////////////////////////////////////////////

  initial begin : mac_side
    logic [31:0] r;
    cycle            = 0;
    pulse_seed       = 39864;
    pkt_tx_full_i    = 1'b0;
    ctrl_tx_enable_i = 1'b1;
    forever begin
      @(posedge xgmii_clk);
      #2;
      cycle++;
      ctrl_tx_enable_i = (cycle >= en_until);
      if (full_on) begin
        r = $random(pulse_seed);
        pkt_tx_full_i = (r[1:0] == 2'd0);
      end else begin
        pkt_tx_full_i = 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output monitor
  ////////////////////////////////////////////////////////////////////////////

  initial begin : monitor
    logic [63:0] mask;
    logic [2:0]  mod_exp;
    logic        full_prev;
    err_data     = 0;
    err_ctrl     = 0;
    err_timing   = 0;
    out_started  = 0;
    stall_cycles = 0;
    exp_rd       = 0;
    full_prev    = 1'b0;
    @(negedge xgmii_clk);
    while (rst_i) @(negedge xgmii_clk);
    if (pkt_tx_val_o !== 1'b0 || pkt_tx_sop_o !== 1'b0 || pkt_tx_eop_o !== 1'b0) begin
      $display("After reset pkt_tx_val_o, sop or eop is not low");
      err_ctrl++;
    end
    if (s_tready_o !== 1'b1) begin
      $display("After reset s_tready_o is not high");
      err_ctrl++;
    end
    forever begin
      if (s_tvalid_i && !s_tready_o) stall_cycles++;
      if (pkt_tx_val_o) begin
        if (pkt_tx_full_i || full_prev) begin
          $display("%s: beat sent while pkt_tx_full_i was high", test_name(cur_test));
          err_timing++;
        end
        if (!ctrl_tx_enable_i) begin
          $display("%s: beat sent while ctrl_tx_enable_i was low", test_name(cur_test));
          err_timing++;
        end
        if (pkt_tx_sop_o) begin
          out_started++;
          if (out_started > tlast_done) begin
            $display("%s: packet started before its tlast beat was taken",
                     test_name(cur_test));
            err_timing++;
          end
        end
        if (exp_rd == exp_wr) begin
          $display("%s: beat sent with no beat expected", test_name(cur_test));
          err_ctrl++;
        end else begin
          mask = '0;
          for (int k = 0; k < exp_cnt[exp_rd]; k++) begin
            mask[8*k +: 8] = 8'hff;
          end
          mod_exp = 3'(exp_cnt[exp_rd] % 8);
          if ((pkt_tx_data_o & mask) !== (exp_data[exp_rd] & mask)) begin
            $display("FAILED %s: beat %0d data expected %h actual %h", test_name(cur_test),
                     exp_rd, exp_data[exp_rd] & mask, pkt_tx_data_o & mask);
            err_data++;
          end
          if (pkt_tx_sop_o !== exp_sop[exp_rd] || pkt_tx_eop_o !== exp_eop[exp_rd]) begin
            $display("FAILED %s: beat %0d sop/eop expected %b%b actual %b%b",
                     test_name(cur_test), exp_rd, exp_sop[exp_rd], exp_eop[exp_rd],
                     pkt_tx_sop_o, pkt_tx_eop_o);
            err_ctrl++;
          end
          if (exp_eop[exp_rd] && pkt_tx_mod_o !== mod_exp) begin
            $display("FAILED %s: beat %0d mod expected %0d actual %0d",
                     test_name(cur_test), exp_rd, mod_exp, pkt_tx_mod_o);
            err_ctrl++;
          end
          exp_rd++;
        end
      end
      full_prev = pkt_tx_full_i;
      @(negedge xgmii_clk);
    end
  end

  // Budget of 40 cycles per table byte on top of a fixed margin
  initial begin : watchdog
    int limit;
    limit = 40 * table_bytes() + 2000;
    repeat (limit) @(posedge xgmii_clk);
    $display("Timeout after %0d cycles with %0d beats still expected", limit,
             exp_wr - exp_rd);
    $display("Test failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    int stall_base;
    int total;
    seed       = 39864;
    rst_i      = 1'b1;
    s_tdata_i  = '0;
    s_tuser_i  = '0;
    s_tlast_i  = 1'b0;
    s_tvalid_i = 1'b0;
    cur_test   = 0;
    full_on    = 1'b0;
    en_until   = 0;
    tlast_done = 0;
    exp_wr     = 0;
    err_flow   = 0;
    repeat (16) @(posedge xgmii_clk);
    #2;
    rst_i = 1'b0;
    for (int t = 0; t < NTEST; t++) begin
      @(posedge xgmii_clk);
      #1;
      cur_test   = t;
      full_on    = (T_FULL[t] != 0);
      en_until   = cycle + T_EN_LOW[t];
      stall_base = stall_cycles;
      #1;
      for (int p = 0; p < T_NPKT[t]; p++) begin
        send_packet(pkt_len(t, p), T_GAP[t]);
      end
      while (exp_rd != exp_wr) begin
        @(posedge xgmii_clk);
        #1;
      end
      full_on = 1'b0;
      if (T_STALL[t] != 0 && stall_cycles == stall_base) begin
        $display("%s: s_tready_o never dropped although the FIFO filled", test_name(t));
        err_flow++;
      end
    end
    repeat (4) @(posedge xgmii_clk);
    total = err_data + err_ctrl + err_timing + err_flow;
    $display("Errors: %0d data, %0d control, %0d timing, %0d flow", err_data, err_ctrl,
             err_timing, err_flow);
    if (total == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: vlog.f
logic/axis_pkg.sv
logic/xge_pkg.sv
logic/axi64_to_xge64.sv
logic/tx_pkt_fifo.sv
logic/tx_pkt_counter.sv
logic/tx_start_fsm.sv
logic/xge_tx_path.sv
tb/tb_xge_tx_path.sv

// File: Makefile
# Verilator flow for the 10G transmit path testbench

TOP = tb_xge_tx_path

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f vlog.f --top-module $(TOP)

# The run passes only if the log holds the pass line
sim:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log
